// ==== src.f ====
+incdir+common
common/fc_num_pkg.sv
common/fc_mem_pkg.sv
rtl/fc_layer_ctrl.sv
fc_neuron/fc_weight_mem.sv
fc_neuron/fc_neuron.sv
rtl/fc_layer.sv
verif/fc_layer_assertions.sv
verif/fc_layer_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fc_layer_tb
FILELIST = src.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/fc_layer_tb.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_layer_tb;

    localparam int n_neurons  = `FC_LAYER_HEIGHT;
    localparam int n_inputs   = `FC_PREV_HEIGHT;
    localparam int wait_limit = 50;
    localparam int n_vectors  = 24;
    localparam longint word_max = 2**(`FC_WORD_SIZE-1) - 1;
    localparam longint word_min = -(2**(`FC_WORD_SIZE-1));

    logic                   clk_i;
    logic                   reset_i;
    fc_num_pkg::word_t      data_i;
    logic                   valid_i;
    logic                   ready_o;
    logic                   valid_o;
    logic                   yumi_i;
    fc_num_pkg::layer_out_t data_o;
    fc_mem_pkg::wr_cmd_t    wr_i;

    // model copy of each neuron memory, bias in the last entry
    fc_num_pkg::word_t model_mem [n_neurons][n_inputs+1];
    fc_num_pkg::word_t in_vec [n_inputs];
    fc_num_pkg::word_t exp_vec [n_neurons];
    logic [31:0]       rng_state;

    fc_layer uut (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (data_i),
        .valid_i (valid_i),
        .ready_o (ready_o),
        .valid_o (valid_o),
        .yumi_i  (yumi_i),
        .data_o  (data_o),
        .wr_i    (wr_i)
    );

    bind fc_layer fc_layer_assertions u_assertions (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (valid_i),
        .in_ready_i  (ready_o),
        .out_valid_i (valid_o),
        .out_yumi_i  (yumi_i),
        .out_data_i  (data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 0 .. n-1
    function automatic int rand_below(input int n);
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'(n));
    endfunction

    // about -4.0 .. +4.0 in q7.8
    function automatic fc_num_pkg::word_t rand_word();
        return fc_num_pkg::word_t'(rand_below(2049) - 1024);
    endfunction

    // inputs change shortly after the edge
    task automatic step();
        @(posedge clk_i);
        #10;
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_word(input int n, input int addr, input fc_num_pkg::word_t w);
        wr_i.en   = 1'b1;
        wr_i.sel  = fc_mem_pkg::neuron_sel_t'(n);
        wr_i.addr = fc_mem_pkg::mem_addr_t'(addr);
        wr_i.data = w;
        model_mem[n][addr] = w;
        step();
        wr_i = '0;
    endtask

    // weights then bias
    // idle cycle at the end lets the registered read see the new word
    task automatic load_neuron(input int n, input logic rand_weights,
                               input fc_num_pkg::word_t w, input fc_num_pkg::word_t b);
        for (int k = 0; k < n_inputs; k++) begin
            load_word(n, k, rand_weights ? rand_word() : w);
        end
        load_word(n, n_inputs, b);
        step();
    endtask

    task automatic random_inputs();
        for (int k = 0; k < n_inputs; k++) begin
            in_vec[k] = rand_word();
        end
    endtask

    // truncated products, bias, clamp to one word, then rectifier
    task automatic run_model();
        longint acc;
        for (int n = 0; n < n_neurons; n++) begin
            acc = 0;
            for (int k = 0; k < n_inputs; k++) begin
                acc += (longint'(in_vec[k]) * longint'(model_mem[n][k])) >>> `FC_FRAC_BITS;
            end
            acc += longint'(model_mem[n][n_inputs]);
            if (acc > word_max) begin
                acc = word_max;
            end else if (acc < word_min) begin
                acc = word_min;
            end
            if (acc < 0) begin
                acc = 0;
            end
            exp_vec[n] = fc_num_pkg::word_t'(acc);
        end
    endtask

    // random idle gaps between beats
    task automatic send_vector();
        int waited;
        for (int k = 0; k < n_inputs; k++) begin
            repeat (rand_below(3)) step();
            valid_i = 1'b1;
            data_i  = in_vec[k];
            waited  = 0;
            while (!ready_o) begin
                step();
                waited++;
                if (waited > wait_limit) begin
                    stop_on_error("timeout waiting for ready_o");
                end
            end
            step();
            valid_i = 1'b0;
            data_i  = '0;
        end
    endtask

    task automatic check_outputs();
        for (int n = 0; n < n_neurons; n++) begin
            assert (data_o[n] == exp_vec[n]) else begin
                stop_on_error($sformatf("error at %0t: neuron %0d gave %0d, expected %0d",
                                        $time, n, data_o[n], exp_vec[n]));
            end
        end
    endtask

    // late consumer, random hold before yumi
    task automatic take_result();
        int waited;
        waited = 0;
        while (!valid_o) begin
            step();
            waited++;
            if (waited > wait_limit) begin
                stop_on_error("timeout waiting for valid_o");
            end
        end
        repeat (rand_below(4)) step();
        check_outputs();
        yumi_i = 1'b1;
        step();
        yumi_i = 1'b0;
    endtask

    task automatic run_vector();
        run_model();
        send_vector();
        take_result();
    endtask

    // every output word known without the model
    task automatic run_vector_expect(input fc_num_pkg::word_t v);
        for (int n = 0; n < n_neurons; n++) begin
            exp_vec[n] = v;
        end
        send_vector();
        take_result();
    endtask

    // assertion failures end the run at the next edge
    always @(posedge clk_i) begin
        if (uut.u_assertions.any_fail === 1'b1) begin
            stop_on_error("a handshake or latency assertion failed");
        end
    end

    initial begin
        rng_state = 32'd66;
        reset_i   = 1'b1;
        valid_i   = 1'b0;
        yumi_i    = 1'b0;
        data_i    = '0;
        wr_i      = '0;
        repeat (4) step();
        reset_i = 1'b0;
        step();

        // random weights, back-to-back vectors
        for (int n = 0; n < n_neurons; n++) begin
            load_neuron(n, 1'b1, '0, rand_word());
        end
        for (int v = 0; v < n_vectors; v++) begin
            random_inputs();
            run_vector();
        end

        // only neuron 2 gets new weights
        load_neuron(2, 1'b1, '0, rand_word());
        repeat (3) begin
            random_inputs();
            run_vector();
        end

        // large positive weights clamp to the top word
        for (int n = 0; n < n_neurons; n++) begin
            load_neuron(n, 1'b0, 16'sh7000, 16'sh7000);
        end
        for (int k = 0; k < n_inputs; k++) begin
            in_vec[k] = 16'sh0400;
        end
        run_vector_expect(fc_num_pkg::word_t'(word_max));

        // bias of -128.0 outweighs any small sum, rectifier gives zero
        for (int n = 0; n < n_neurons; n++) begin
            load_neuron(n, 1'b1, '0, 16'sh8000);
        end
        random_inputs();
        run_vector_expect('0);

        // fresh weights again, accumulators start from zero
        for (int n = 0; n < n_neurons; n++) begin
            load_neuron(n, 1'b1, '0, rand_word());
        end
        random_inputs();
        run_vector();
        step();

        if (uut.u_assertions.any_fail === 1'b1) begin
            stop_on_error("a handshake or latency assertion failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== verif/fc_layer_assertions.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_layer_assertions (
    input logic                   clk_i,
    input logic                   reset_i,
    input logic                   in_valid_i,
    input logic                   in_ready_i,
    input logic                   out_valid_i,
    input logic                   out_yumi_i,
    input fc_num_pkg::layer_out_t out_data_i
);

    // failure flags, one per property
    logic reset_fail = 1'b0;
    logic excl_fail  = 1'b0;
    logic hold_fail  = 1'b0;
    logic lat_fail   = 1'b0;
    logic rise_fail  = 1'b0;
    logic any_fail;

    logic        accept;
    logic        last_accept;
    int unsigned beats;

    assign any_fail = reset_fail || excl_fail || hold_fail || lat_fail || rise_fail;

    // accepted input beats of the current vector
    assign accept      = in_valid_i && in_ready_i;
    assign last_accept = accept && (beats == `FC_PREV_HEIGHT - 1);

    always_ff @(posedge clk_i) begin
        if (reset_i || last_accept) begin
            beats <= 0;
        end else if (accept) begin
            beats <= beats + 1;
        end
    end

    // out of reset: ready for input, nothing offered
    reset_state: assert property (@(posedge clk_i) reset_i |=> in_ready_i && !out_valid_i)
        else begin
            reset_fail = 1'b1;
            $error("ready_o or valid_o wrong after reset");
        end

    // input side and output side never open together
    no_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
        !(in_ready_i && out_valid_i))
        else begin
            excl_fail = 1'b1;
            $error("ready_o and valid_o high in the same cycle");
        end

    // result held under back-pressure
    hold_result: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_i && !out_yumi_i |=> out_valid_i && $stable(out_data_i))
        else begin
            hold_fail = 1'b1;
            $error("output vector changed before yumi_i");
        end

    // bias step, then the result two edges after the last input
    fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        last_accept |=> !out_valid_i ##1 out_valid_i)
        else begin
            lat_fail = 1'b1;
            $error("valid_o late after the last input");
        end

    result_source: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(out_valid_i) |-> $past(last_accept, 2))
        else begin
            rise_fail = 1'b1;
            $error("valid_o rose without a full vector");
        end

endmodule

// ==== rtl/fc_layer.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_layer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // input stream
    input  fc_num_pkg::word_t      data_i,
    input  logic                   valid_i,
    output logic                   ready_o,
    // output vector
    output logic                   valid_o,
    input  logic                   yumi_i,
    output fc_num_pkg::layer_out_t data_o,
    // weight load
    input  fc_mem_pkg::wr_cmd_t    wr_i
);

    // shared neuron controls
    fc_mem_pkg::mem_addr_t       rd_addr;
    fc_mem_pkg::mem_addr_t       wr_addr;
    fc_num_pkg::word_t           wr_data;
    logic                        sum_en;
    logic                        add_bias;
    logic                        clear;
    logic [`FC_LAYER_HEIGHT-1:0] wen;

    fc_layer_ctrl u_ctrl (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .yumi_i     (yumi_i),
        .wr_i       (wr_i),
        .ready_o    (ready_o),
        .valid_o    (valid_o),
        .sum_en_o   (sum_en),
        .add_bias_o (add_bias),
        .clear_o    (clear),
        .rd_addr_o  (rd_addr),
        .wen_o      (wen),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data)
    );

    // one neuron per output word, data_i broadcast to all
    for (genvar i = 0; i < `FC_LAYER_HEIGHT; i++) begin : g_neuron
        fc_neuron u_neuron (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .sum_en_i   (sum_en),
            .add_bias_i (add_bias),
            .clear_i    (clear),
            .wen_i      (wen[i]),
            .data_i     (data_i),
            .wr_data_i  (wr_data),
            .rd_addr_i  (rd_addr),
            .wr_addr_i  (wr_addr),
            .data_o     (data_o[i])
        );
    end

endmodule

// ==== fc_neuron/fc_neuron.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_neuron (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  sum_en_i,
    input  logic                  add_bias_i,
    input  logic                  clear_i,
    input  logic                  wen_i,
    input  fc_num_pkg::word_t     data_i,
    input  fc_num_pkg::word_t     wr_data_i,
    input  fc_mem_pkg::mem_addr_t rd_addr_i,
    input  fc_mem_pkg::mem_addr_t wr_addr_i,
    output fc_num_pkg::word_t     data_o
);

    // word range in accumulator width
    localparam fc_num_pkg::acc_t word_max = fc_num_pkg::acc_t'(2**(`FC_WORD_SIZE-1) - 1);
    localparam fc_num_pkg::acc_t word_min = -fc_num_pkg::acc_t'(2**(`FC_WORD_SIZE-1));

    fc_num_pkg::word_t weight;
    fc_num_pkg::prod_t prod;
    fc_num_pkg::prod_t prod_scaled;
    fc_num_pkg::acc_t  addend;
    fc_num_pkg::acc_t  acc_r;
    fc_num_pkg::acc_t  acc_n;
    fc_num_pkg::word_t sat_word;
    fc_num_pkg::word_t relu_word;
    fc_num_pkg::word_t out_r;

    // weight or bias word, lined up with data_i
    fc_weight_mem u_mem (
        .clk_i     (clk_i),
        .wen_i     (wen_i),
        .wr_addr_i (wr_addr_i),
        .rd_addr_i (rd_addr_i),
        .wr_data_i (wr_data_i),
        .rd_data_o (weight)
    );

    // full product, then drop the extra fraction bits
    assign prod        = fc_num_pkg::prod_t'(data_i) * fc_num_pkg::prod_t'(weight);
    assign prod_scaled = prod >>> `FC_FRAC_BITS;

    // bias step adds the stored word as is
    assign addend = add_bias_i ? fc_num_pkg::acc_t'(weight)
                               : fc_num_pkg::acc_t'(prod_scaled);

    assign acc_n = acc_r + addend;

    // clamp to one word
    always_comb begin
        if (acc_n > word_max) begin
            sat_word = word_max[`FC_WORD_SIZE-1:0];
        end else if (acc_n < word_min) begin
            sat_word = word_min[`FC_WORD_SIZE-1:0];
        end else begin
            sat_word = acc_n[`FC_WORD_SIZE-1:0];
        end
    end

    // rectifier
    assign relu_word = sat_word[`FC_WORD_SIZE-1] ? '0 : sat_word;

    // accumulator and output register move together,
    // so the output is final on the bias edge
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            acc_r <= '0;
            out_r <= '0;
        end else if (sum_en_i) begin
            acc_r <= acc_n;
            out_r <= relu_word;
        end
    end

    assign data_o = out_r;

endmodule

// ==== fc_neuron/fc_weight_mem.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_weight_mem (
    input  logic                  clk_i,
    input  logic                  wen_i,
    input  fc_mem_pkg::mem_addr_t wr_addr_i,
    input  fc_mem_pkg::mem_addr_t rd_addr_i,
    input  fc_num_pkg::word_t     wr_data_i,
    output fc_num_pkg::word_t     rd_data_o
);

    // weights then bias, one word per entry
    fc_num_pkg::word_t mem [0:`FC_PREV_HEIGHT];

    // write port
    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read
    // address of cycle n arrives in cycle n-1
    // a same-address write still returns the old word
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== rtl/fc_layer_ctrl.sv ====
`timescale 1ns/100ps
`include "fc_config.svh"

module fc_layer_ctrl (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  logic                  yumi_i,
    input  fc_mem_pkg::wr_cmd_t   wr_i,
    output logic                  ready_o,
    output logic                  valid_o,
    output logic                  sum_en_o,
    output logic                  add_bias_o,
    output logic                  clear_o,
    output fc_mem_pkg::mem_addr_t rd_addr_o,
    output logic [`FC_LAYER_HEIGHT-1:0] wen_o,
    output fc_mem_pkg::mem_addr_t wr_addr_o,
    output fc_num_pkg::word_t     wr_data_o
);

    typedef enum logic [1:0] {
        s_accept,
        s_bias,
        s_done
    } state_t;

    state_t state_r;
    state_t state_n;

    // accepted inputs of the current vector
    fc_mem_pkg::mem_addr_t cnt_r;
    fc_mem_pkg::mem_addr_t cnt_n;

    logic accept;

    // beat taken on this edge
    assign accept = (state_r == s_accept) && valid_i;

    // next state
    always_comb begin
        state_n = state_r;
        case (state_r)
            s_accept: begin
                // last input of the vector moves on to the bias step
                if (accept && (cnt_r == `FC_PREV_HEIGHT-1)) begin
                    state_n = s_bias;
                end
            end
            s_bias: begin
                state_n = s_done;
            end
            s_done: begin
                // hold the result until the consumer takes it
                if (yumi_i) begin
                    state_n = s_accept;
                end
            end
            default: begin
                state_n = s_accept;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= s_accept;
        end else begin
            state_r <= state_n;
        end
    end

    // counter runs 0 .. FC_PREV_HEIGHT, the last value is the bias address
    always_comb begin
        if (state_r == s_done) begin
            cnt_n = '0;
        end else if (accept) begin
            cnt_n = cnt_r + 1'b1;
        end else begin
            cnt_n = cnt_r;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_r <= '0;
        end else begin
            cnt_r <= cnt_n;
        end
    end

    // ram read is registered, so look one beat ahead
    assign rd_addr_o = cnt_n;

    // handshake and neuron strobes
    assign ready_o    = (state_r == s_accept);
    assign valid_o    = (state_r == s_done);
    assign sum_en_o   = accept || (state_r == s_bias);
    assign add_bias_o = (state_r == s_bias);
    assign clear_o    = (state_r == s_done) && yumi_i;

    // neuron select to one-hot write enables
    always_comb begin
        for (int i = 0; i < `FC_LAYER_HEIGHT; i++) begin
            wen_o[i] = wr_i.en && (wr_i.sel == fc_mem_pkg::neuron_sel_t'(i));
        end
    end

    // write port takes the command's address and word in the same cycle
    assign wr_addr_o = wr_i.addr;
    assign wr_data_o = wr_i.data;

endmodule

// ==== common/fc_mem_pkg.sv ====
`include "fc_config.svh"

package fc_mem_pkg;

    // address inside one neuron memory
    // weights at 0 .. FC_PREV_HEIGHT-1, bias at FC_PREV_HEIGHT
    typedef logic [$clog2(`FC_PREV_HEIGHT+1)-1:0] mem_addr_t;

    // neuron index, at least one bit
    typedef logic [((`FC_LAYER_HEIGHT > 1) ? $clog2(`FC_LAYER_HEIGHT) : 1)-1:0] neuron_sel_t;

    // one weight-load beat
    typedef struct packed {
        logic              en;
        neuron_sel_t       sel;
        mem_addr_t         addr;
        fc_num_pkg::word_t data;
    } wr_cmd_t;

endpackage

// ==== common/fc_num_pkg.sv ====
`include "fc_config.svh"

package fc_num_pkg;

    // one signed fixed-point word
    typedef logic signed [`FC_WORD_SIZE-1:0] word_t;

    // full-width product of two words
    typedef logic signed [2*`FC_WORD_SIZE-1:0] prod_t;

    // accumulator, two words plus four guard bits
    // guard bits keep a full vector of worst-case products from wrapping
    typedef logic signed [2*`FC_WORD_SIZE+3:0] acc_t;

    // output vector, neuron i on word i
    typedef word_t [`FC_LAYER_HEIGHT-1:0] layer_out_t;

endpackage

// ==== common/fc_config.svh ====
`ifndef FC_CONFIG_SVH
`define FC_CONFIG_SVH

// width of one activation, weight, bias or output word
`define FC_WORD_SIZE 16

// fractional bits of the fixed-point format (q7.8 for 16 bits)
`define FC_FRAC_BITS 8

// neurons in this layer, one output word each
`define FC_LAYER_HEIGHT 4

// input words per vector, one weight per input
`define FC_PREV_HEIGHT 6

// each neuron memory holds FC_PREV_HEIGHT weights then the bias

`endif
